// ==== logic/slowMulDiv_config.svh ====
// width must be at least 2 and lanes at least 1; tag width sets how many operations can be in flight
`ifndef SLOWMULDIV_CONFIG_SVH
`define SLOWMULDIV_CONFIG_SVH

// operand and result width in bits
// 32 and 64 are the intended sizes
`define MD_WIDTH 32

// number of shift-add engines in the cluster
// each engine holds one operation from start until drained
`define MD_LANES 4

// tag that travels with each operation
// caller keeps tags unique while in flight
`define MD_TAG_BITS 4

// one operation takes MD_WIDTH run cycles plus load, fix and drain
// so throughput is about MD_LANES per MD_WIDTH+4 cycles

`endif

// ==== logic/slowMulDivPkg.sv ====
// shared enums only; opcode encoding is fixed at 3 bits and lane state at 2 bits
`default_nettype none

package slowMulDivPkg;

	// opcodes accepted on the issue port
	// low product is the same for signed and unsigned
	typedef enum logic [2:0]
	{
		opMul,
		opMulh,
		opMulhu,
		opDiv,
		opDivu,
		opRem,
		opRemu
	} mulDivOp_t;

	// per-engine state
	// stFix is the single sign fixup cycle
	typedef enum logic [1:0]
	{
		stIdle,
		stRun,
		stFix,
		stDone
	} laneState_t;

endpackage

`default_nettype wire

// ==== logic/opDispatcher.sv ====
// issue is a plain strobe with no handshake; an issue while busy is high is dropped and flagged
`timescale 1ns/1ps
`default_nettype none

`include "slowMulDiv_config.svh"

module opDispatcher
(
	input  wire                           clock,
	input  wire                           reset,
	input  wire                           issue,
	input  slowMulDivPkg::mulDivOp_t      issueOp,
	input  wire [`MD_WIDTH-1:0]           issueA,
	input  wire [`MD_WIDTH-1:0]           issueB,
	input  wire [`MD_TAG_BITS-1:0]        issueTag,
	input  wire [`MD_LANES-1:0]           laneIdle,
	output logic                          busy,
	output logic [`MD_LANES-1:0]          laneStart,
	output slowMulDivPkg::mulDivOp_t      laneOp,
	output logic [`MD_WIDTH-1:0]          laneA,
	output logic [`MD_WIDTH-1:0]          laneB,
	output logic [`MD_TAG_BITS-1:0]       laneTag
);

	// idle lanes not already claimed by a start pulse
	logic [`MD_LANES-1:0] laneFree;
	// one-hot choice of the lowest free lane
	logic [`MD_LANES-1:0] lanePick;
	logic                 accept;

	assign laneFree = laneIdle & ~laneStart;

	// lowest index wins
	always_comb
	begin
		logic found;
		found = 1'b0;
		lanePick = '0;
		for (int i = 0; i < `MD_LANES; i++)
		begin
			if (laneFree[i] && !found)
			begin
				lanePick[i] = 1'b1;
				found = 1'b1;
			end
		end
	end

	// busy only when every lane is running, done or being started
	assign busy = ~|laneFree;
	assign accept = issue && !busy;

	// start pulse lasts exactly one cycle
	always_ff @(posedge clock)
	begin
		if (reset)
			laneStart <= '0;
		else if (accept)
			laneStart <= lanePick;
		else
			laneStart <= '0;
	end

	// shared operation bus, read by the started lane only
	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			laneOp <= issueOp;
			laneA <= issueA;
			laneB <= issueB;
			laneTag <= issueTag;
		end
	end

	// upstream must watch busy before issuing
	issueNotBusy: assert property (@(posedge clock) disable iff (reset) issue |-> !busy)
		else $error("issue while busy");

endmodule

`default_nettype wire

// ==== logic/shiftAddUnit.sv ====
// one bit per cycle, so a result takes MD_WIDTH+2 cycles after start; start only while idle
`timescale 1ns/1ps
`default_nettype none

`include "slowMulDiv_config.svh"

module shiftAddUnit
(
	input  wire                           clock,
	input  wire                           reset,
	input  wire                           start,
	input  slowMulDivPkg::mulDivOp_t      op,
	input  wire [`MD_WIDTH-1:0]           a,
	input  wire [`MD_WIDTH-1:0]           b,
	input  wire [`MD_TAG_BITS-1:0]        tag,
	input  wire                           take,
	output logic                          idle,
	output logic                          done,
	output logic [`MD_WIDTH-1:0]          value,
	output logic                          divZero,
	output logic [`MD_TAG_BITS-1:0]       doneTag
);

	localparam int W = `MD_WIDTH;
	localparam int CNT_BITS = $clog2(`MD_WIDTH);

	slowMulDivPkg::laneState_t state;
	logic [CNT_BITS-1:0] count;

	// latched operation
	slowMulDivPkg::mulDivOp_t opReg;
	logic                     negReg;
	logic                     zeroDivReg;

	// high half or partial remainder
	logic [W-1:0] rem;
	// multiplier, then low product or quotient
	logic [W-1:0] qr;
	// multiplicand, or negated divisor
	logic [W-1:0] addend;

	// operand decode at start
	logic         startSigned;
	logic         startIsDiv;
	logic         aNeg;
	logic         bNeg;
	logic [W-1:0] aMag;
	logic [W-1:0] bMag;

	// the one adder
	logic         isDiv;
	logic [W:0]   addLeft;
	logic [W:0]   addRight;
	logic [W:0]   addSum;

	// fixup results
	logic [W-1:0] mulHi;
	logic [W-1:0] quot;
	logic [W-1:0] remOut;
	logic [W-1:0] result;

	assign startSigned = (op == slowMulDivPkg::opMulh) || (op == slowMulDivPkg::opDiv) ||
		(op == slowMulDivPkg::opRem);
	assign startIsDiv = (op == slowMulDivPkg::opDiv) || (op == slowMulDivPkg::opDivu) ||
		(op == slowMulDivPkg::opRem) || (op == slowMulDivPkg::opRemu);
	assign aNeg = startSigned && a[W-1];
	assign bNeg = startSigned && b[W-1];
	assign aMag = aNeg ? -a : a;
	assign bMag = bNeg ? -b : b;

	assign isDiv = (opReg == slowMulDivPkg::opDiv) || (opReg == slowMulDivPkg::opDivu) ||
		(opReg == slowMulDivPkg::opRem) || (opReg == slowMulDivPkg::opRemu);

	always_comb
	begin
		if (isDiv)
		begin
			// shifted remainder plus sign-extended negative divisor
			addLeft = {rem, qr[W-1]};
			addRight = {1'b1, addend};
		end
		else
		begin
			// high half plus multiplicand, carry kept
			addLeft = {1'b0, rem};
			addRight = {1'b0, addend};
		end
		addSum = addLeft + addRight;
	end

	// negated 2W product, high half only
	assign mulHi = negReg ? (~rem + {{(W-1){1'b0}}, (qr == '0)}) : rem;
	assign quot = negReg ? -qr : qr;
	assign remOut = negReg ? -rem : rem;

	// most-negative by minus one gives quotient 100..0 with positive sign,
	// which is the dividend, and remainder zero
	// zero divisor leaves rem at |a| with the dividend sign, i.e. the dividend
	always_comb
	begin
		case (opReg)
			slowMulDivPkg::opMulh,
			slowMulDivPkg::opMulhu: result = mulHi;
			slowMulDivPkg::opDiv,
			slowMulDivPkg::opDivu: result = zeroDivReg ? '1 : quot;
			slowMulDivPkg::opRem,
			slowMulDivPkg::opRemu: result = remOut;
			default: result = qr;
		endcase
	end

	// control
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= slowMulDivPkg::stIdle;
			count <= '0;
		end
		else
		begin
			case (state)
				slowMulDivPkg::stIdle:
				begin
					if (start)
					begin
						state <= slowMulDivPkg::stRun;
						count <= CNT_BITS'(W - 1);
					end
				end
				slowMulDivPkg::stRun:
				begin
					count <= count - 1'b1;
					if (count == '0)
						state <= slowMulDivPkg::stFix;
				end
				slowMulDivPkg::stFix: state <= slowMulDivPkg::stDone;
				default:
				begin
					// held until the collector drains it
					if (take)
						state <= slowMulDivPkg::stIdle;
				end
			endcase
		end
	end

	// datapath
	always_ff @(posedge clock)
	begin
		if (state == slowMulDivPkg::stIdle && start)
		begin
			opReg <= op;
			doneTag <= tag;
			// remainder carries the dividend sign
			negReg <= (op == slowMulDivPkg::opRem) ? aNeg : (aNeg ^ bNeg);
			zeroDivReg <= startIsDiv && (b == '0);
			rem <= '0;
			qr <= aMag;
			addend <= startIsDiv ? -bMag : bMag;
		end
		else if (state == slowMulDivPkg::stRun)
		begin
			if (isDiv)
			begin
				// restoring step
				rem <= addSum[W] ? addLeft[W-1:0] : addSum[W-1:0];
				qr <= {qr[W-2:0], ~addSum[W]};
			end
			else if (qr[0])
				{rem, qr} <= {addSum, qr[W-1:1]};
			else
				{rem, qr} <= {1'b0, rem, qr[W-1:1]};
		end
		else if (state == slowMulDivPkg::stFix)
			value <= result;
	end

	assign idle = (state == slowMulDivPkg::stIdle);
	assign done = (state == slowMulDivPkg::stDone);
	assign divZero = zeroDivReg;

	// dispatcher only starts idle lanes
	startWhenIdle: assert property (@(posedge clock) disable iff (reset)
		start |-> state == slowMulDivPkg::stIdle)
		else $error("start to a lane that is not idle");

	// collector only drains finished lanes
	takeWhenDone: assert property (@(posedge clock) disable iff (reset)
		take |-> state == slowMulDivPkg::stDone)
		else $error("take to a lane that is not done");

endmodule

`default_nettype wire

// ==== logic/resultCollector.sv ====
// one result per cycle at most, lowest lane first; there is no back-pressure on the result port
`timescale 1ns/1ps
`default_nettype none

`include "slowMulDiv_config.svh"

module resultCollector
(
	input  wire                           clock,
	input  wire                           reset,
	input  wire [`MD_LANES-1:0]           laneDone,
	input  wire [`MD_WIDTH-1:0]           laneValue [`MD_LANES],
	input  wire [`MD_LANES-1:0]           laneDivZero,
	input  wire [`MD_TAG_BITS-1:0]        laneTag [`MD_LANES],
	output logic [`MD_LANES-1:0]          laneTake,
	output logic                          resultValid,
	output logic [`MD_WIDTH-1:0]          resultValue,
	output logic                          resultDivZero,
	output logic [`MD_TAG_BITS-1:0]       resultTag
);

	// fields of the selected lane
	logic [`MD_WIDTH-1:0]    selValue;
	logic                    selDivZero;
	logic [`MD_TAG_BITS-1:0] selTag;

	// fixed priority, lane 0 first
	// take drops once the lane has left stDone
	always_comb
	begin
		logic found;
		found = 1'b0;
		laneTake = '0;
		selValue = '0;
		selDivZero = 1'b0;
		selTag = '0;
		for (int i = 0; i < `MD_LANES; i++)
		begin
			if (laneDone[i] && !found)
			begin
				laneTake[i] = 1'b1;
				selValue = laneValue[i];
				selDivZero = laneDivZero[i];
				selTag = laneTag[i];
				found = 1'b1;
			end
		end
	end

	// valid is a one-cycle pulse per drained lane
	always_ff @(posedge clock)
	begin
		if (reset)
			resultValid <= 1'b0;
		else
			resultValid <= |laneDone;
	end

	// payload
	always_ff @(posedge clock)
	begin
		resultValue <= selValue;
		resultDivZero <= selDivZero;
		resultTag <= selTag;
	end

	// a drained lane has left stDone by the next edge
	drainOnce: assert property (@(posedge clock) disable iff (reset)
		|laneTake |=> (laneDone & $past(laneTake)) == '0)
		else $error("lane still done after it was drained");

endmodule

`default_nettype wire

// ==== logic/slowMulDivCluster.sv ====
// results may leave out of issue order, so the caller matches them by tag
`timescale 1ns/1ps
`default_nettype none

`include "slowMulDiv_config.svh"

module slowMulDivCluster
(
	input  wire                           clock,
	input  wire                           reset,
	input  wire                           issue,
	input  slowMulDivPkg::mulDivOp_t      issueOp,
	input  wire [`MD_WIDTH-1:0]           issueA,
	input  wire [`MD_WIDTH-1:0]           issueB,
	input  wire [`MD_TAG_BITS-1:0]        issueTag,
	output logic                          busy,
	output logic                          resultValid,
	output logic [`MD_WIDTH-1:0]          resultValue,
	output logic                          resultDivZero,
	output logic [`MD_TAG_BITS-1:0]       resultTag
);

	// shared operation bus from the dispatcher
	slowMulDivPkg::mulDivOp_t busOp;
	logic [`MD_WIDTH-1:0]     busA;
	logic [`MD_WIDTH-1:0]     busB;
	logic [`MD_TAG_BITS-1:0]  busTag;

	// per-lane handshake levels and pulses
	logic [`MD_LANES-1:0]     laneStart;
	logic [`MD_LANES-1:0]     laneIdle;
	logic [`MD_LANES-1:0]     laneDone;
	logic [`MD_LANES-1:0]     laneTake;
	logic [`MD_LANES-1:0]     laneDivZero;
	logic [`MD_WIDTH-1:0]     laneValue [`MD_LANES];
	logic [`MD_TAG_BITS-1:0]  laneDoneTag [`MD_LANES];

	opDispatcher dispatch0
	(
		.clock(clock), .reset(reset), .issue(issue), .issueOp(issueOp), .issueA(issueA),
		.issueB(issueB), .issueTag(issueTag), .laneIdle(laneIdle), .busy(busy),
		.laneStart(laneStart), .laneOp(busOp), .laneA(busA), .laneB(busB), .laneTag(busTag)
	);

	// identical engines
	for (genvar lane = 0; lane < `MD_LANES; lane++)
	begin : gLane
		shiftAddUnit unit0
		(
			.clock(clock), .reset(reset), .start(laneStart[lane]), .op(busOp), .a(busA),
			.b(busB), .tag(busTag), .take(laneTake[lane]), .idle(laneIdle[lane]),
			.done(laneDone[lane]), .value(laneValue[lane]), .divZero(laneDivZero[lane]),
			.doneTag(laneDoneTag[lane])
		);
	end

	resultCollector collect0
	(
		.clock(clock), .reset(reset), .laneDone(laneDone), .laneValue(laneValue),
		.laneDivZero(laneDivZero), .laneTag(laneDoneTag), .laneTake(laneTake),
		.resultValid(resultValid), .resultValue(resultValue),
		.resultDivZero(resultDivZero), .resultTag(resultTag)
	);

endmodule

`default_nettype wire

// ==== tests/mulDivModel.svh ====
// include inside a module; model is good up to MD_WIDTH 64, LFSR is 32 bits with one bit per step
`ifndef MULDIVMODEL_SVH
`define MULDIVMODEL_SVH

`include "slowMulDiv_config.svh"

// expected {divZero, value} for one operation
function automatic logic [`MD_WIDTH:0] mulDivModel
(
	input slowMulDivPkg::mulDivOp_t op,
	input logic [`MD_WIDTH-1:0]     a,
	input logic [`MD_WIDTH-1:0]     b
);
	logic [2*`MD_WIDTH-1:0] prod;
	logic [`MD_WIDTH-1:0]   value;
	logic                   zero;
	logic                   overflow;
	logic                   isDiv;
	zero = (b == '0);
	// most negative by minus one
	overflow = (a == {1'b1, {(`MD_WIDTH-1){1'b0}}}) && (b == '1);
	isDiv = (op == slowMulDivPkg::opDiv) || (op == slowMulDivPkg::opDivu) ||
		(op == slowMulDivPkg::opRem) || (op == slowMulDivPkg::opRemu);
	value = '0;
	prod = '0;
	case (op)
		slowMulDivPkg::opMul:
		begin
			prod = {{`MD_WIDTH{1'b0}}, a} * {{`MD_WIDTH{1'b0}}, b};
			value = prod[`MD_WIDTH-1:0];
		end
		slowMulDivPkg::opMulh:
		begin
			// sign-extended to double width first
			prod = $signed({{`MD_WIDTH{a[`MD_WIDTH-1]}}, a}) *
				$signed({{`MD_WIDTH{b[`MD_WIDTH-1]}}, b});
			value = prod[2*`MD_WIDTH-1:`MD_WIDTH];
		end
		slowMulDivPkg::opMulhu:
		begin
			prod = {{`MD_WIDTH{1'b0}}, a} * {{`MD_WIDTH{1'b0}}, b};
			value = prod[2*`MD_WIDTH-1:`MD_WIDTH];
		end
		slowMulDivPkg::opDiv:
		begin
			// signed divide kept in its own statement so it stays signed
			if (zero)
				value = '1;
			else if (overflow)
				value = a;
			else
				value = $signed(a) / $signed(b);
		end
		slowMulDivPkg::opDivu:
			value = zero ? '1 : a / b;
		// remainder keeps the dividend sign
		slowMulDivPkg::opRem:
		begin
			if (zero)
				value = a;
			else if (overflow)
				value = '0;
			else
				value = $signed(a) % $signed(b);
		end
		slowMulDivPkg::opRemu:
			value = zero ? a : a % b;
		default:
			value = '0;
	endcase
	return {isDiv && zero, value};
endfunction

// one Galois step, taps x^32+x^22+x^2+x+1
function automatic logic [31:0] lfsrNext(input logic [31:0] state);
	logic [31:0] next;
	next = state >> 1;
	if (state[0])
		next = next ^ 32'h80200003;
	return next;
endfunction

`endif

// ==== tests/slowMulDivTb.sv ====
// self-checking run of directed and random operations; needs MD_TAG_BITS of at least 3
`timescale 1ns/1ps
`default_nettype none

`include "slowMulDiv_config.svh"

module slowMulDivTb;

	localparam int W = `MD_WIDTH;
	localparam int NTAGS = 1 << `MD_TAG_BITS;
	localparam int BURST = 40;
	// directed multiply, divide, zero divisor, then the burst
	localparam int TOTAL_OPS = 30 + 40 + 24 + BURST;
	localparam int LIMIT = TOTAL_OPS * (W + 4 + `MD_LANES) + 200;
	localparam logic [W-1:0] MIN = {1'b1, {(W-1){1'b0}}};

	`include "mulDivModel.svh"

	logic                     clock;
	logic                     reset;
	logic                     issue;
	slowMulDivPkg::mulDivOp_t issueOp;
	logic [W-1:0]             issueA;
	logic [W-1:0]             issueB;
	logic [`MD_TAG_BITS-1:0]  issueTag;
	logic                     busy;
	logic                     resultValid;
	logic [W-1:0]             resultValue;
	logic                     resultDivZero;
	logic [`MD_TAG_BITS-1:0]  resultTag;

	// scoreboard by tag
	logic [W-1:0]             expValue [NTAGS];
	logic                     expFlag [NTAGS];
	slowMulDivPkg::mulDivOp_t expOp [NTAGS];
	logic                     pending [NTAGS];
	logic [`MD_TAG_BITS-1:0]  nextTag;
	int outstanding;
	int errorCount;
	int checkCount;
	int testErrors;
	int testsPassed;
	int testsFailed;
	int cycleCount;
	logic [31:0] lfsr;
	logic sawBusy;

	slowMulDivCluster dut0
	(
		.clock(clock), .reset(reset), .issue(issue), .issueOp(issueOp), .issueA(issueA),
		.issueB(issueB), .issueTag(issueTag), .busy(busy), .resultValid(resultValid),
		.resultValue(resultValue), .resultDivZero(resultDivZero), .resultTag(resultTag)
	);

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	task automatic checkValue(input slowMulDivPkg::mulDivOp_t op,
		input logic [`MD_TAG_BITS-1:0] tag, input logic [W-1:0] expected,
		input logic [W-1:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("[ERROR] resultValue tag 0x%0h %s expected 0x%h got 0x%h",
				tag, op.name(), expected, actual);
		end
	endtask

	task automatic checkFlag(input slowMulDivPkg::mulDivOp_t op,
		input logic [`MD_TAG_BITS-1:0] tag, input logic expected, input logic actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("[ERROR] resultDivZero tag 0x%0h %s expected 0x%h got 0x%h",
				tag, op.name(), expected, actual);
		end
	endtask

	// single-bit status outputs
	task automatic checkLevel(input string name, input logic expected, input logic actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("[ERROR] %s expected 0x%h got 0x%h", name, expected, actual);
		end
	endtask

	task automatic takeBits(input int n, output logic [W-1:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsrNext(lfsr);
			bits = {bits[W-2:0], lfsr[0]};
		end
	endtask

	// called and left at 10 ns after a rising edge
	task automatic sendOperation(input slowMulDivPkg::mulDivOp_t op, input logic [W-1:0] a,
		input logic [W-1:0] b);
		logic [W:0] expected;
		// hold off while lanes are full or the tag is still out
		while (busy || pending[nextTag])
		begin
			if (busy)
				sawBusy = 1'b1;
			issue = 1'b0;
			@(posedge clock);
			#10;
		end
		expected = mulDivModel(op, a, b);
		expValue[nextTag] = expected[W-1:0];
		expFlag[nextTag] = expected[W];
		expOp[nextTag] = op;
		pending[nextTag] = 1'b1;
		outstanding++;
		issue = 1'b1;
		issueOp = op;
		issueA = a;
		issueB = b;
		issueTag = nextTag;
		nextTag = nextTag + 1'b1;
		@(posedge clock);
		#10;
		issue = 1'b0;
	endtask

	task automatic waitDrained();
		while (outstanding != 0)
		begin
			@(posedge clock);
			#10;
		end
	endtask

	task automatic endTest(input string name);
		if (errorCount == testErrors)
		begin
			testsPassed++;
			$display("test %s: ok", name);
		end
		else
		begin
			testsFailed++;
			$display("test %s: failed with %0d errors", name, errorCount - testErrors);
		end
		testErrors = errorCount;
	endtask

	// pairs with every sign combination and the extremes, as {a, b}
	function automatic logic [2*W-1:0] directedPair(input int i);
		case (i)
			0: return {W'(7), W'(3)};
			1: return {W'(-7), W'(3)};
			2: return {W'(7), W'(-3)};
			3: return {W'(-7), W'(-3)};
			4: return {W'(0), W'(5)};
			5: return {MIN, W'(-1)};
			6: return {MIN, W'(1)};
			7: return {~MIN, ~MIN};
			8: return {W'(-1), W'(-1)};
			default: return {~MIN, W'(2)};
		endcase
	endfunction

	// monitor samples the result port at the falling edge
	always @(negedge clock)
	begin
		if (!reset && resultValid === 1'b1)
		begin
			if (!pending[resultTag])
			begin
				errorCount++;
				$display("result with tag %0d arrived but that tag was not outstanding",
					resultTag);
			end
			else
			begin
				checkValue(expOp[resultTag], resultTag, expValue[resultTag], resultValue);
				checkFlag(expOp[resultTag], resultTag, expFlag[resultTag], resultDivZero);
				pending[resultTag] = 1'b0;
				outstanding--;
			end
		end
	end

	// watchdog
	always @(posedge clock)
	begin
		cycleCount++;
		if (cycleCount >= LIMIT)
		begin
			$display("timeout after %0d cycles with %0d results missing", cycleCount,
				outstanding);
			for (int t = 0; t < NTAGS; t++)
				if (pending[t])
					$display("tag %0d never returned", t);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	initial
	begin
		logic [2*W-1:0] pair;
		logic [W-1:0]   r;
		logic [W-1:0]   rs;
		logic [W-1:0]   ra;
		logic [W-1:0]   rb;
		reset = 1'b1;
		issue = 1'b0;
		issueOp = slowMulDivPkg::opMul;
		issueA = '0;
		issueB = '0;
		issueTag = '0;
		nextTag = '0;
		outstanding = 0;
		errorCount = 0;
		checkCount = 0;
		testErrors = 0;
		testsPassed = 0;
		testsFailed = 0;
		cycleCount = 0;
		lfsr = 32'd37;
		sawBusy = 1'b0;
		for (int t = 0; t < NTAGS; t++)
			pending[t] = 1'b0;
		repeat (16) @(posedge clock);
		#10;
		reset = 1'b0;

		// quiet after reset
		repeat (8)
		begin
			@(negedge clock);
			checkLevel("busy", 1'b0, busy);
			checkLevel("resultValid", 1'b0, resultValid);
		end
		@(posedge clock);
		#10;
		endTest("idle after reset");

		for (int i = 0; i < 10; i++)
			for (int k = 0; k < 3; k++)
			begin
				pair = directedPair(i);
				sendOperation(slowMulDivPkg::mulDivOp_t'(3'(k)), pair[2*W-1:W], pair[W-1:0]);
			end
		waitDrained();
		endTest("directed multiply");

		for (int i = 0; i < 10; i++)
			for (int k = 3; k < 7; k++)
			begin
				pair = directedPair(i);
				sendOperation(slowMulDivPkg::mulDivOp_t'(3'(k)), pair[2*W-1:W], pair[W-1:0]);
			end
		waitDrained();
		endTest("directed divide and remainder");

		// same dividends over a zero divisor
		for (int i = 0; i < 6; i++)
			for (int k = 3; k < 7; k++)
			begin
				pair = directedPair(i);
				sendOperation(slowMulDivPkg::mulDivOp_t'(3'(k)), pair[2*W-1:W], '0);
			end
		waitDrained();
		endTest("divide by zero");

		sawBusy = 1'b0;
		for (int n = 0; n < BURST; n++)
		begin
			takeBits(3, r);
			takeBits(W, ra);
			takeBits(W, rb);
			takeBits(2, rs);
			// a quarter get a small divisor, so quotients have more bits
			if (rs[1:0] == 2'b00)
				rb = rb & W'(255);
			sendOperation(slowMulDivPkg::mulDivOp_t'(3'(r[2:0] % 7)), ra, rb);
		end
		waitDrained();
		if (!sawBusy)
		begin
			errorCount++;
			$display("busy was never seen high during the random burst");
		end
		endTest("random burst");

		$display("tests passed %0d, failed %0d, checks %0d, errors %0d", testsPassed,
			testsFailed, checkCount, errorCount);
		if (errorCount == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+logic
+incdir+tests
logic/slowMulDivPkg.sv
logic/opDispatcher.sv
logic/shiftAddUnit.sv
logic/resultCollector.sv
logic/slowMulDivCluster.sv
tests/slowMulDivTb.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then decide on the pass line in the log
rm -rf obj_dir sim.log \
	&& verilator --binary --timing --assert -Wno-fatal -f src.f \
		--top-module slowMulDivTb -o simv \
	&& (./obj_dir/simv > sim.log 2>&1 || true) \
	&& cat sim.log \
	&& grep -qF '*** TEST PASSED ***' sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
